// ==== vlog.f ====
+incdir+include
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpuCore.sv
sim/cpuTb.sv

// ==== sim/cpuTb.sv ====
`default_nettype none

`include "cpu_consts.svh"

module cpuTb import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk, rstN;
    logic                  instrRead, dataRead, dataWrite, outputStrobe, halted;
    logic [`WORD_SIZE-1:0] instrAddr, instrData, dataAddr, dataWrData, dataRdData;
    logic [`WORD_SIZE-1:0] outputPort, numInst;

    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] refMem [256];   // data memory as the ISA model leaves it
    logic [15:0] expOut [$];     // WWD values in program order
    logic [31:0] lfsrState = 32'h37c9_5637;
    int          progLen = 0;
    int          outIdx = 0;
    int          cycles = 0;
    int          cycleLimit = 0;
    string       testName = "";

    cpuCore cpuCore_inst (.clk, .rstN, .instrRead, .instrAddr, .instrData, .dataRead,
        .dataWrite, .dataAddr, .dataWrData, .dataRdData, .outputPort, .outputStrobe,
        .numInst, .halted);

    assign instrData  = imem[instrAddr[7:0]];
    // combinational read, data only while dataRead is high
    assign dataRdData = dataRead ? dmem[dataAddr[7:0]] : 'x;

    always @(posedge clk) begin
        if (dataWrite)
            dmem[dataAddr[7:0]] <= dataWrData;
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: core did not halt within %0d cycles", cycleLimit);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    // galois form, one step per bit
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
        end
        return r;
    endfunction

    function automatic logic [15:0] fillWord(input logic [7:0] a);
        return {a ^ 8'h5a, ~a + 8'd3};
    endfunction

    function automatic logic [15:0] encR(input funcE fn, input logic [1:0] rs, rt, rd);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encI(input opcodeE op, input logic [1:0] rs, rt,
                                         input logic [15:0] imm);
        return {op, rs, rt, imm[7:0]};
    endfunction

    function automatic logic [15:0] encJ(input int target);
        return {OP_JMP, 12'(target)};
    endfunction

    task automatic emit(input logic [15:0] ins);
        imem[progLen] = ins;
        progLen++;
    endtask

    // plain ISA interpreter, returns executed count with HLT
    function automatic int refRun();
        logic [15:0] regs [4];
        logic [15:0] ins, pc, a, b, simm, addr;
        int          count;
        regs  = '{default: '0};
        pc    = `RESET_PC;
        count = 0;
        expOut.delete();
        for (int i = 0; i < 256; i++)
            refMem[i] = fillWord(i[7:0]);
        while (count < 2000) begin
            ins  = imem[pc[7:0]];
            pc   = pc + 16'd1;
            count++;
            a    = regs[ins[11:10]];
            b    = regs[ins[9:8]];
            simm = {{8{ins[7]}}, ins[7:0]};
            addr = a + simm;
            case (ins[15:12])
                OP_RTYPE: case (ins[5:0])
                    FN_ADD: regs[ins[7:6]] = a + b;
                    FN_SUB: regs[ins[7:6]] = a - b;
                    FN_AND: regs[ins[7:6]] = a & b;
                    FN_ORR: regs[ins[7:6]] = a | b;
                    FN_NOT: regs[ins[7:6]] = ~a;
                    FN_TCP: regs[ins[7:6]] = 16'd0 - a;
                    FN_SHL: regs[ins[7:6]] = {a[14:0], 1'b0};
                    FN_SHR: regs[ins[7:6]] = {a[15], a[15:1]};
                    FN_WWD: expOut.push_back(a);
                    FN_HLT: return count;
                    default: ;
                endcase
                OP_ADI: regs[ins[9:8]] = addr;
                OP_ORI: regs[ins[9:8]] = a | {8'h00, ins[7:0]};
                OP_LHI: regs[ins[9:8]] = {ins[7:0], 8'h00};
                OP_LWD: regs[ins[9:8]] = refMem[addr[7:0]];
                OP_SWD: refMem[addr[7:0]] = b;
                OP_BNE: if (a != b) pc = pc + simm;
                OP_BEQ: if (a == b) pc = pc + simm;
                OP_JMP: pc = {pc[15:12], ins[11:0]};
                default: ;
            endcase
        end
        return count;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected, actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h actual %h", testName, what, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    // strobes compared in order as they leave MEM/WB
    always @(negedge clk) begin
        if (rstN && outputStrobe) begin
            if (outIdx < expOut.size())
                checkValue("wwd value", 32'(expOut[outIdx]), 32'(outputPort));
            outIdx++;
        end
    end

    task automatic runTest(input string name);
        int expCount;
        testName   = name;
        expCount   = refRun();
        cycleLimit += 3 * expCount + 50;
        @(negedge clk);
        rstN = 1'b0;
        for (int a = 0; a < 256; a++)
            dmem[a] <= fillWord(a[7:0]);
        repeat (10) @(negedge clk);
        checkValue("numInst after reset", 0, 32'(numInst));
        checkValue("halted after reset", 0, 32'(halted));
        checkValue("pc after reset", 32'(`RESET_PC), 32'(instrAddr));
        checkValue("strobes after reset", 4'b1000,
                   32'({instrRead, dataRead, dataWrite, outputStrobe}));
        outIdx = 0;
        rstN   = 1'b1;
        while (!halted)
            @(negedge clk);
        repeat (8) @(negedge clk);   // spin on HLT, nothing more may come out
        checkValue("halted stays high", 1, 32'(halted));
        checkValue("wwd count", expOut.size(), outIdx);
        checkValue("numInst", expCount, 32'(numInst));
        for (int a = 0; a < 256; a++)
            checkValue("data memory", 32'(refMem[a]), 32'(dmem[a]));
    endtask

    task automatic buildArith();
        logic [1:0] rd, prevRd;
        progLen = 0;
        for (int r = 0; r < 4; r++)
            emit(encI(OP_ADI, 2'd0, r[1:0], randBits(8)));
        prevRd = 2'd1;
        for (int k = 0; k < 16; k++) begin
            rd = 2'(randBits(2));
            emit(encR(funcE'(k % 8), prevRd, 2'(randBits(2)), rd));   // rs from two back
            emit(encR(FN_WWD, rd, 2'd0, 2'd0));                       // result of the op just before
            prevRd = rd;
        end
        emit(encR(FN_HLT, 2'd0, 2'd0, 2'd0));
    endtask

    task automatic buildMemory();
        progLen = 0;
        for (int i = 0; i < 3; i++) begin
            emit(encI(OP_LHI, 2'd0, 2'd1, randBits(8)));
            emit(encI(OP_ORI, 2'd1, 2'd1, randBits(8)));
            emit(encR(FN_WWD, 2'd1, 2'd0, 2'd0));
            emit(encI(OP_SWD, 2'd0, 2'd1, 16'(8 + i)));
            emit(encI(OP_LWD, 2'd0, 2'd2, 16'(8 + i)));
            emit(encR(FN_ADD, 2'd2, 2'd1, 2'd3));   // load-use
            emit(encR(FN_WWD, 2'd3, 2'd0, 2'd0));
        end
        emit(encI(OP_LWD, 2'd0, 2'd2, 16'h0040));   // untouched fill word
        emit(encR(FN_WWD, 2'd2, 2'd0, 2'd0));
        emit(encR(FN_HLT, 2'd0, 2'd0, 2'd0));
    endtask

    task automatic buildBranch();
        logic [15:0] x;
        progLen = 0;
        // low two loop bits walk BNE/BEQ through equal and unequal operands
        for (int i = 0; i < 8; i++) begin
            x = randBits(8);
            emit(encI(OP_ADI, 2'd0, 2'd1, x));
            emit(encI(OP_ADI, 2'd0, 2'd2, i[0] ? x : x ^ 16'h0024));
            emit(encI(i[1] ? OP_BEQ : OP_BNE, 2'd1, 2'd2, 16'd2));
            emit(encR(FN_WWD, 2'd1, 2'd0, 2'd0));   // skipped when taken
            emit(encI(OP_ADI, 2'd3, 2'd3, 16'd1));
            emit(encR(FN_WWD, 2'd3, 2'd0, 2'd0));   // target
        end
        // branch fed by a load
        emit(encI(OP_SWD, 2'd0, 2'd1, 16'h0030));
        emit(encI(OP_LWD, 2'd0, 2'd2, 16'h0030));
        emit(encI(OP_BEQ, 2'd1, 2'd2, 16'd1));
        emit(encR(FN_WWD, 2'd1, 2'd0, 2'd0));
        emit(encR(FN_WWD, 2'd2, 2'd0, 2'd0));
        emit(encR(FN_HLT, 2'd0, 2'd0, 2'd0));
    endtask

    task automatic buildJump();
        progLen = 0;
        emit(encI(OP_ADI, 2'd0, 2'd1, randBits(8)));
        for (int i = 0; i < 3; i++) begin
            emit(encJ(progLen + 4));
            emit(encR(FN_WWD, 2'd1, 2'd0, 2'd0));   // skipped block
            emit(encI(OP_ADI, 2'd1, 2'd1, 16'd1));
            emit(encR(FN_WWD, 2'd1, 2'd0, 2'd0));
            emit(encI(OP_ADI, 2'd1, 2'd1, 16'd3));   // jump lands here
            emit(encR(FN_WWD, 2'd1, 2'd0, 2'd0));
        end
        emit(encR(FN_HLT, 2'd0, 2'd0, 2'd0));
    endtask

    task automatic buildHalt();
        progLen = 0;
        emit(encI(OP_ADI, 2'd0, 2'd1, randBits(8)));
        emit(encI(OP_ADI, 2'd1, 2'd2, randBits(8)));
        emit(encR(FN_ADD, 2'd1, 2'd2, 2'd3));
        emit(encR(FN_WWD, 2'd3, 2'd0, 2'd0));
        emit(encI(OP_SWD, 2'd0, 2'd3, 16'h0010));
        emit(encR(FN_HLT, 2'd0, 2'd0, 2'd0));
        emit(encR(FN_WWD, 2'd1, 2'd0, 2'd0));   // never executes
        emit(encI(OP_ADI, 2'd1, 2'd1, 16'd1));
        emit(encR(FN_WWD, 2'd1, 2'd0, 2'd0));
    endtask

    initial begin
        rstN = 1'b0;
        buildArith();
        runTest("arith chain");
        buildMemory();
        runTest("load store");
        buildBranch();
        runTest("branches");
        buildJump();
        runTest("jump");
        buildHalt();
        runTest("halt");
        runTest("halt after reset");   // same program again from reset
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/cpuCore.sv ====
`default_nettype none

`include "cpu_consts.svh"

module cpuCore import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    output logic                  instrRead,
    output logic [`WORD_SIZE-1:0] instrAddr,
    input  logic [`WORD_SIZE-1:0] instrData,
    output logic                  dataRead,
    output logic                  dataWrite,
    output logic [`WORD_SIZE-1:0] dataAddr,
    output logic [`WORD_SIZE-1:0] dataWrData,
    input  logic [`WORD_SIZE-1:0] dataRdData,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  outputStrobe,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic                  halted
);

    ifIdT                  ifId;
    idExT                  idEx;
    exMemT                 exMem;
    memWbT                 memWb;
    logic                  stall, redirect, exRegWrite, wbRegWrite;
    logic [`WORD_SIZE-1:0] redirectPc, exResult, wbData;
    logic [1:0]            exRd, wbRd;

    fetchStage fetchStage_inst (.clk, .rstN, .stall, .redirect, .redirectPc, .instrData,
        .instrAddr, .instrRead, .ifId);

    decodeStage decodeStage_inst (.clk, .rstN, .ifId, .exMem, .exResult, .exRd, .exRegWrite,
        .wbRegWrite, .wbRd, .wbData, .stall, .redirect, .redirectPc, .idEx);

    executeStage executeStage_inst (.clk, .rstN, .idEx, .exMem, .wbRegWrite, .wbRd, .wbData,
        .exResult, .exRd, .exRegWrite);

    memoryStage memoryStage_inst (.clk, .rstN, .exMem, .dataRdData, .dataRead, .dataWrite,
        .dataAddr, .dataWrData, .memWb, .wbRegWrite, .wbRd, .wbData);

    assign outputStrobe = memWb.ctrl.isWwd;
    assign outputPort   = memWb.outVal;

    // count lags MEM/WB by one cycle, halted likewise
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            numInst <= '0;
            halted  <= 1'b0;
        end else begin
            numInst <= numInst + `WORD_SIZE'(memWb.ctrl.retire);
            if (memWb.ctrl.isHalt)
                halted <= 1'b1;   // sticky until reset
        end
    end

endmodule

`default_nettype wire

// ==== logic/memoryStage.sv ====
`default_nettype none

`include "cpu_consts.svh"

module memoryStage import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  exMemT                 exMem,
    input  logic [`WORD_SIZE-1:0] dataRdData,
    output logic                  dataRead,
    output logic                  dataWrite,
    output logic [`WORD_SIZE-1:0] dataAddr,
    output logic [`WORD_SIZE-1:0] dataWrData,
    output memWbT                 memWb,
    output logic                  wbRegWrite,
    output logic [1:0]            wbRd,
    output logic [`WORD_SIZE-1:0] wbData
);

    assign dataRead   = exMem.ctrl.memRead;
    assign dataWrite  = exMem.ctrl.memWrite;
    assign dataAddr   = exMem.aluResult;   // rs + imm
    assign dataWrData = exMem.storeVal;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb.ctrl      <= exMem.ctrl;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadVal   <= dataRdData;   // valid same cycle as dataRead
            memWb.outVal    <= exMem.outVal;
            memWb.rd        <= exMem.rd;
        end
    end

    assign wbRegWrite = memWb.ctrl.regWrite;
    assign wbRd       = memWb.rd;
    assign wbData     = memWb.ctrl.memToReg ? memWb.loadVal : memWb.aluResult;

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`default_nettype none

`include "cpu_consts.svh"

module executeStage import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  idExT                  idEx,
    output exMemT                 exMem,
    input  logic                  wbRegWrite,
    input  logic [1:0]            wbRd,
    input  logic [`WORD_SIZE-1:0] wbData,
    output logic [`WORD_SIZE-1:0] exResult,
    output logic [1:0]            exRd,
    output logic                  exRegWrite
);

    logic [`WORD_SIZE-1:0] fwdRs, fwdRt, opA, opB, aluOut;

    // picks up load data that decode could not see
    always_comb begin
        fwdRs = idEx.rsVal;
        if (exMem.ctrl.regWrite && exMem.rd == idEx.rs)
            fwdRs = exMem.aluResult;
        else if (wbRegWrite && wbRd == idEx.rs)
            fwdRs = wbData;
        fwdRt = idEx.rtVal;
        if (exMem.ctrl.regWrite && exMem.rd == idEx.rt)
            fwdRt = exMem.aluResult;
        else if (wbRegWrite && wbRd == idEx.rt)
            fwdRt = wbData;
    end

    assign opA = idEx.ctrl.zeroSrcA ? '0 : fwdRs;
    assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : fwdRt;

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_ADD: aluOut = opA + opB;
            ALU_SUB: aluOut = opA - opB;
            ALU_AND: aluOut = opA & opB;
            ALU_OR:  aluOut = opA | opB;
            ALU_NOT: aluOut = ~opA;
            ALU_TCP: aluOut = ~opA + `WORD_SIZE'd1;
            ALU_SHL: aluOut = opA << 1;
            ALU_SHR: aluOut = {opA[15], opA[15:1]};   // arithmetic
            default: aluOut = opA;
        endcase
    end

    assign exResult   = aluOut;
    assign exRd       = idEx.rd;
    assign exRegWrite = idEx.ctrl.regWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem.ctrl      <= idEx.ctrl;
            exMem.aluResult <= aluOut;
            exMem.storeVal  <= fwdRt;   // SWD data
            exMem.outVal    <= fwdRs;   // WWD value
            exMem.rd        <= idEx.rd;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`default_nettype none

`include "cpu_consts.svh"

module decodeStage import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  ifIdT                  ifId,
    input  exMemT                 exMem,
    input  logic [`WORD_SIZE-1:0] exResult,
    input  logic [1:0]            exRd,
    input  logic                  exRegWrite,
    input  logic                  wbRegWrite,
    input  logic [1:0]            wbRd,
    input  logic [`WORD_SIZE-1:0] wbData,
    output logic                  stall,
    output logic                  redirect,
    output logic [`WORD_SIZE-1:0] redirectPc,
    output idExT                  idEx
);

    logic [`WORD_SIZE-1:0] regFile [`NUM_REGS];
    logic [`WORD_SIZE-1:0] rsVal, rtVal, imm, haltPc;
    logic [1:0]            rs, rt, rd;
    opcodeE                opcode;
    funcE                  func;
    ctrlT                  ctrl;
    logic                  rsUsed, rtUsed, isBranch, isJump, taken;
    logic                  haltSeen, loadHazard, branchHazard;

    assign opcode = opcodeE'(ifId.instr[15:12]);
    assign func   = funcE'(ifId.instr[5:0]);
    assign rs     = ifId.instr[11:10];
    assign rt     = ifId.instr[9:8];

    always_comb begin
        ctrl     = '0;
        rsUsed   = 1'b0;
        rtUsed   = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        rd       = rt;                                      // I-type writes rt
        imm      = {{8{ifId.instr[7]}}, ifId.instr[7:0]};   // sign extended
        if (ifId.instr != '0 && !haltSeen) begin
            ctrl.retire = 1'b1;
            case (opcode)
                OP_RTYPE: begin
                    rd = ifId.instr[7:6];
                    case (func)
                        FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
                            rsUsed        = 1'b1;
                            rtUsed        = 1'b1;
                            ctrl.regWrite = 1'b1;
                            ctrl.aluOp    = aluOpE'(ifId.instr[2:0]);
                        end
                        FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                            rsUsed        = 1'b1;
                            ctrl.regWrite = 1'b1;
                            ctrl.aluOp    = aluOpE'(ifId.instr[2:0]);
                        end
                        FN_WWD: begin
                            rsUsed     = 1'b1;
                            ctrl.isWwd = 1'b1;
                        end
                        FN_HLT: ctrl.isHalt = 1'b1;
                        default: ;   // unknown function retires as a nop
                    endcase
                end
                OP_ADI, OP_ORI, OP_LWD: begin
                    rsUsed         = 1'b1;
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.memRead   = (opcode == OP_LWD);
                    ctrl.memToReg  = (opcode == OP_LWD);
                    ctrl.aluOp     = (opcode == OP_ORI) ? ALU_OR : ALU_ADD;
                    if (opcode == OP_ORI)
                        imm = {8'h00, ifId.instr[7:0]};
                end
                OP_LHI: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.zeroSrcA  = 1'b1;
                    ctrl.aluOp     = ALU_OR;
                    imm            = {ifId.instr[7:0], 8'h00};
                end
                OP_SWD: begin
                    rsUsed         = 1'b1;
                    rtUsed         = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.memWrite  = 1'b1;
                end
                OP_BNE, OP_BEQ: begin
                    rsUsed   = 1'b1;
                    rtUsed   = 1'b1;
                    isBranch = 1'b1;
                end
                OP_JMP:  isJump = 1'b1;
                default: ;
            endcase
        end
    end

    // newest first: EX result, EX/MEM, writeback, then the file
    always_comb begin
        rsVal = regFile[rs];
        if (exRegWrite && exRd == rs)
            rsVal = exResult;
        else if (exMem.ctrl.regWrite && !exMem.ctrl.memRead && exMem.rd == rs)
            rsVal = exMem.aluResult;
        else if (wbRegWrite && wbRd == rs)
            rsVal = wbData;
        rtVal = regFile[rt];
        if (exRegWrite && exRd == rt)
            rtVal = exResult;
        else if (exMem.ctrl.regWrite && !exMem.ctrl.memRead && exMem.rd == rt)
            rtVal = exMem.aluResult;
        else if (wbRegWrite && wbRd == rt)
            rtVal = wbData;
    end

    assign loadHazard = idEx.ctrl.memRead &&
                        ((rsUsed && idEx.rd == rs) || (rtUsed && idEx.rd == rt));
    // load data is not visible here while the load sits in EX/MEM
    assign branchHazard = isBranch && exMem.ctrl.memRead && (exMem.rd == rs || exMem.rd == rt);
    assign stall        = loadHazard || branchHazard;
    assign taken        = isBranch && ((rsVal == rtVal) == (opcode == OP_BEQ));

    always_comb begin
        redirect   = 1'b0;
        redirectPc = ifId.pcPlus1 + imm;   // branch target
        if (haltSeen) begin
            redirect   = 1'b1;             // spin on the HLT
            redirectPc = haltPc;
        end else if (!stall) begin
            if (ctrl.isHalt) begin
                redirect   = 1'b1;
                redirectPc = ifId.pcPlus1 - `WORD_SIZE'd1;
            end else if (isJump) begin
                redirect   = 1'b1;
                redirectPc = {ifId.pcPlus1[15:12], ifId.instr[11:0]};
            end else if (taken) begin
                redirect = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haltSeen <= 1'b0;
            haltPc   <= `RESET_PC;
        end else if (ctrl.isHalt && !stall) begin
            haltSeen <= 1'b1;
            haltPc   <= ifId.pcPlus1 - `WORD_SIZE'd1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            regFile <= '{default: '0};
        else if (wbRegWrite)
            regFile[wbRd] <= wbData;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else begin
            idEx.ctrl  <= stall ? ctrlT'('0) : ctrl;   // bubble on load-use
            idEx.rsVal <= rsVal;
            idEx.rtVal <= rtVal;
            idEx.imm   <= imm;
            idEx.rs    <= rs;
            idEx.rt    <= rt;
            idEx.rd    <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetchStage.sv ====
`default_nettype none

`include "cpu_consts.svh"

module fetchStage import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  logic                  redirect,
    input  logic [`WORD_SIZE-1:0] redirectPc,
    input  logic [`WORD_SIZE-1:0] instrData,
    output logic [`WORD_SIZE-1:0] instrAddr,
    output logic                  instrRead,
    output ifIdT                  ifId
);

    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] pcPlus1;

    assign pcPlus1   = pc + `WORD_SIZE'd1;
    assign instrAddr = pc;
    assign instrRead = 1'b1;   // fetch every cycle, memory answers in the same cycle

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc   <= `RESET_PC;
            ifId <= '0;
        end else if (redirect) begin
            pc   <= redirectPc;
            ifId <= '0;             // instruction zero is the bubble
        end else if (!stall) begin
            pc           <= pcPlus1;
            ifId.pcPlus1 <= pcPlus1;
            ifId.instr   <= instrData;
        end
        // stall holds pc and IF/ID
    end

endmodule

`default_nettype wire

// ==== logic/cpuPkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcodeE;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funcE;

    // same order as the low three function bits
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  aluSrcImm;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  isWwd;
        logic  isHalt;
        logic  zeroSrcA;   // LHI passes the immediate through OR
        aluOpE aluOp;
        logic  retire;     // clear for bubbles
    } ctrlT;

    typedef struct packed {
        logic [`WORD_SIZE-1:0] pcPlus1;
        logic [`WORD_SIZE-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [`WORD_SIZE-1:0] rsVal;
        logic [`WORD_SIZE-1:0] rtVal;
        logic [`WORD_SIZE-1:0] imm;
        logic [1:0]            rs;
        logic [1:0]            rt;
        logic [1:0]            rd;
    } idExT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [`WORD_SIZE-1:0] aluResult;
        logic [`WORD_SIZE-1:0] storeVal;
        logic [`WORD_SIZE-1:0] outVal;
        logic [1:0]            rd;
    } exMemT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [`WORD_SIZE-1:0] aluResult;
        logic [`WORD_SIZE-1:0] loadVal;
        logic [`WORD_SIZE-1:0] outVal;
        logic [1:0]            rd;
    } memWbT;

endpackage

`default_nettype wire

// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath width in bits
`define WORD_SIZE 16

// general registers r0..r3
`define NUM_REGS 4

// first fetch address after reset
`define RESET_PC 16'h0000

`endif
